// File: source/llc_pkg.sv
package llc_pkg;

    localparam int LLC_WAYS       = 4;
    localparam int LLC_WAY_BITS   = $clog2(LLC_WAYS);
    localparam int LLC_SET_BITS   = 4;
    localparam int LLC_SETS       = 16;
    localparam int LLC_TAG_BITS   = 12;
    localparam int LINE_ADDR_BITS = LLC_TAG_BITS + LLC_SET_BITS;
    localparam int LINE_BITS      = 64;
    localparam int REQ_ID_BITS    = 4;

    typedef logic [LINE_ADDR_BITS-1:0] line_addr_t;  // tag in the upper bits, set below
    typedef logic [LLC_SET_BITS-1:0]   llc_set_t;
    typedef logic [LLC_TAG_BITS-1:0]   llc_tag_t;
    typedef logic [LLC_WAY_BITS-1:0]   llc_way_t;
    typedef logic [LINE_BITS-1:0]      line_t;
    typedef logic [REQ_ID_BITS-1:0]    req_id_t;

    typedef enum logic [2:0] {
        DECODE     = 3'b000,
        READ_SET   = 3'b001,
        LOOKUP     = 3'b011,
        WRITE_BACK = 3'b010,
        FILL       = 3'b110,
        UPDATE     = 3'b111,
        RESPOND    = 3'b100
    } llc_state_t;

endpackage

// File: source/llc_tag_store.sv
module llc_tag_store import llc_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     rd_en_i,
    input  llc_set_t set_i,
    input  logic     wr_en_i,
    input  llc_way_t wr_way_i,
    input  llc_tag_t wr_tag_i,
    input  logic     wr_dirty_i,
    input  logic     advance_i,
    input  llc_tag_t tag_i,
    output logic     hit_o,
    output llc_way_t hit_way_o,
    output llc_way_t victim_way_o,
    output logic     victim_valid_o,
    output logic     victim_dirty_o,
    output llc_tag_t victim_tag_o
);

    logic [LLC_WAYS-1:0] valid_q [LLC_SETS];
    logic [LLC_WAYS-1:0] dirty_q [LLC_SETS];
    llc_tag_t            tag_q   [LLC_SETS][LLC_WAYS];
    llc_way_t            evict_q [LLC_SETS];  // round-robin pointer of each set

    logic     hit_c;
    llc_way_t hit_way_c;
    llc_way_t evict_way;

    assign evict_way = evict_q[set_i];

    always_comb begin
        hit_c = 1'b0;
        hit_way_c = '0;
        for (int w = 0; w < LLC_WAYS; w++) begin
            if (valid_q[set_i][w] && (tag_q[set_i][w] == tag_i)) begin
                hit_c = 1'b1;
                hit_way_c = llc_way_t'(w);
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < LLC_SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
                evict_q[s] <= '0;
            end
        end else begin
            if (wr_en_i) begin
                valid_q[set_i][wr_way_i] <= 1'b1;
                dirty_q[set_i][wr_way_i] <= wr_dirty_i;
            end
            if (advance_i) begin
                evict_q[set_i] <= evict_q[set_i] + 1'b1;  // wraps after the last way
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            tag_q[set_i][wr_way_i] <= wr_tag_i;
        end
    end

    // lookup results stay put until the next read of a set
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            hit_o <= 1'b0;
            hit_way_o <= '0;
            victim_way_o <= '0;
            victim_valid_o <= 1'b0;
            victim_dirty_o <= 1'b0;
            victim_tag_o <= '0;
        end else if (rd_en_i) begin
            hit_o <= hit_c;
            hit_way_o <= hit_way_c;
            victim_way_o <= evict_way;
            victim_valid_o <= valid_q[set_i][evict_way];
            victim_dirty_o <= dirty_q[set_i][evict_way];
            victim_tag_o <= tag_q[set_i][evict_way];
        end
    end

endmodule

// File: source/llc_line_store.sv
module llc_line_store import llc_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     rd_en_i,
    input  llc_set_t set_i,
    input  logic     wr_en_i,
    input  llc_way_t wr_way_i,
    input  line_t    wr_line_i,
    output line_t    lines_o [LLC_WAYS]
);

    line_t mem_q [LLC_SETS][LLC_WAYS];

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem_q[set_i][wr_way_i] <= wr_line_i;  // one way per write
        end
    end

    // the whole set is handed to the controller at once
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int w = 0; w < LLC_WAYS; w++) begin
                lines_o[w] <= '0;
            end
        end else if (rd_en_i) begin
            for (int w = 0; w < LLC_WAYS; w++) begin
                lines_o[w] <= mem_q[set_i][w];
            end
        end
    end

endmodule

// File: source/llc_ctrl.sv
module llc_ctrl import llc_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       req_valid_i,
    output logic       req_ready_o,
    input  logic       req_write_i,
    input  line_addr_t req_addr_i,
    input  line_t      req_line_i,
    input  req_id_t    req_id_i,
    output logic       rsp_valid_o,
    input  logic       rsp_ready_i,
    output line_t      rsp_line_o,
    output req_id_t    rsp_id_o,
    output logic       mem_req_valid_o,
    input  logic       mem_req_ready_i,
    output logic       mem_req_write_o,
    output line_addr_t mem_req_addr_o,
    output line_t      mem_req_line_o,
    input  logic       mem_rsp_valid_i,
    output logic       mem_rsp_ready_o,
    input  line_t      mem_rsp_line_i,
    output logic       rd_en_o,
    output llc_set_t   set_o,
    output llc_tag_t   tag_o,
    output logic       wr_en_o,
    output llc_way_t   wr_way_o,
    output llc_tag_t   wr_tag_o,
    output logic       wr_dirty_o,
    output line_t      wr_line_o,
    output logic       advance_o,
    input  logic       hit_i,
    input  llc_way_t   hit_way_i,
    input  llc_way_t   victim_way_i,
    input  logic       victim_valid_i,
    input  logic       victim_dirty_i,
    input  llc_tag_t   victim_tag_i,
    input  line_t      lines_i [LLC_WAYS]
);

    llc_state_t state, next_state;
    logic       req_write_q;
    line_addr_t req_addr_q;
    line_t      req_line_q;
    req_id_t    req_id_q;
    line_t      line_q;
    logic       fill_sent_q;
    llc_set_t   req_set;
    llc_tag_t   req_tag;
    llc_way_t   way_sel;
    logic       mem_rsp_fire;

    assign req_set = req_addr_q[LLC_SET_BITS-1:0];
    assign req_tag = req_addr_q[LLC_SET_BITS +: LLC_TAG_BITS];
    assign way_sel = hit_i ? hit_way_i : victim_way_i;  // store outputs hold until the next read
    assign mem_rsp_fire = mem_rsp_valid_i && mem_rsp_ready_o;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= DECODE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            DECODE: if (req_valid_i) next_state = READ_SET;
            READ_SET: next_state = LOOKUP;
            LOOKUP: begin
                if (hit_i) begin
                    next_state = UPDATE;
                end else if (victim_valid_i && victim_dirty_i) begin
                    next_state = WRITE_BACK;
                end else begin
                    next_state = FILL;
                end
            end
            WRITE_BACK: if (mem_req_ready_i) next_state = FILL;
            FILL: if (mem_rsp_fire) next_state = UPDATE;
            UPDATE: next_state = RESPOND;
            RESPOND: if (rsp_ready_i) next_state = DECODE;
            default: next_state = DECODE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (req_valid_i && req_ready_o) begin
            req_write_q <= req_write_i;
            req_addr_q <= req_addr_i;
            req_line_q <= req_line_i;
            req_id_q <= req_id_i;
        end
    end

    // holds the victim for a write-back until the fill replaces it
    always_ff @(posedge clk) begin
        if (state == LOOKUP) begin
            line_q <= (hit_i && req_write_q) ? req_line_q : lines_i[way_sel];
        end else if (mem_rsp_fire) begin
            line_q <= req_write_q ? req_line_q : mem_rsp_line_i;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            fill_sent_q <= 1'b0;
        end else if (mem_rsp_fire) begin
            fill_sent_q <= 1'b0;
        end else if (state == FILL && mem_req_ready_i) begin
            fill_sent_q <= 1'b1;  // read issued, now waiting for the line
        end
    end

    assign req_ready_o = (state == DECODE);
    assign rd_en_o = (state == READ_SET);
    assign set_o = req_set;
    assign tag_o = req_tag;

    assign mem_req_valid_o = (state == WRITE_BACK) || (state == FILL && !fill_sent_q);
    assign mem_req_write_o = (state == WRITE_BACK);
    assign mem_req_addr_o = (state == WRITE_BACK) ? {victim_tag_i, req_set} : req_addr_q;
    assign mem_req_line_o = line_q;
    assign mem_rsp_ready_o = (state == FILL) && fill_sent_q;

    // a read hit changes nothing, so its dirty bit stays as it was
    assign wr_en_o = (state == UPDATE) && (req_write_q || !hit_i);
    assign wr_way_o = way_sel;
    assign wr_tag_o = req_tag;
    assign wr_dirty_o = req_write_q;
    assign wr_line_o = line_q;
    assign advance_o = (state == UPDATE) && !hit_i;

    assign rsp_valid_o = (state == RESPOND);
    assign rsp_line_o = line_q;
    assign rsp_id_o = req_id_q;

endmodule

// File: source/llc_top.sv
module llc_top import llc_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       req_valid_i,
    output logic       req_ready_o,
    input  logic       req_write_i,
    input  line_addr_t req_addr_i,
    input  line_t      req_line_i,
    input  req_id_t    req_id_i,
    output logic       rsp_valid_o,
    input  logic       rsp_ready_i,
    output line_t      rsp_line_o,
    output req_id_t    rsp_id_o,
    output logic       mem_req_valid_o,
    input  logic       mem_req_ready_i,
    output logic       mem_req_write_o,
    output line_addr_t mem_req_addr_o,
    output line_t      mem_req_line_o,
    input  logic       mem_rsp_valid_i,
    output logic       mem_rsp_ready_o,
    input  line_t      mem_rsp_line_i
);

    logic     rd_en;
    llc_set_t set;
    llc_tag_t tag;
    logic     wr_en;
    llc_way_t wr_way;
    llc_tag_t wr_tag;
    logic     wr_dirty;
    line_t    wr_line;
    logic     advance;
    logic     hit;
    llc_way_t hit_way;
    llc_way_t victim_way;
    logic     victim_valid;
    logic     victim_dirty;
    llc_tag_t victim_tag;
    line_t    lines [LLC_WAYS];

    llc_ctrl u_ctrl (
        .clk             (clk),
        .rst             (rst),
        .req_valid_i     (req_valid_i),
        .req_ready_o     (req_ready_o),
        .req_write_i     (req_write_i),
        .req_addr_i      (req_addr_i),
        .req_line_i      (req_line_i),
        .req_id_i        (req_id_i),
        .rsp_valid_o     (rsp_valid_o),
        .rsp_ready_i     (rsp_ready_i),
        .rsp_line_o      (rsp_line_o),
        .rsp_id_o        (rsp_id_o),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_ready_i (mem_req_ready_i),
        .mem_req_write_o (mem_req_write_o),
        .mem_req_addr_o  (mem_req_addr_o),
        .mem_req_line_o  (mem_req_line_o),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .mem_rsp_ready_o (mem_rsp_ready_o),
        .mem_rsp_line_i  (mem_rsp_line_i),
        .rd_en_o         (rd_en),
        .set_o           (set),
        .tag_o           (tag),
        .wr_en_o         (wr_en),
        .wr_way_o        (wr_way),
        .wr_tag_o        (wr_tag),
        .wr_dirty_o      (wr_dirty),
        .wr_line_o       (wr_line),
        .advance_o       (advance),
        .hit_i           (hit),
        .hit_way_i       (hit_way),
        .victim_way_i    (victim_way),
        .victim_valid_i  (victim_valid),
        .victim_dirty_i  (victim_dirty),
        .victim_tag_i    (victim_tag),
        .lines_i         (lines)
    );

    // both stores see the same set index and read strobe
    llc_tag_store u_tag_store (
        .clk            (clk),
        .rst            (rst),
        .rd_en_i        (rd_en),
        .set_i          (set),
        .wr_en_i        (wr_en),
        .wr_way_i       (wr_way),
        .wr_tag_i       (wr_tag),
        .wr_dirty_i     (wr_dirty),
        .advance_i      (advance),
        .tag_i          (tag),
        .hit_o          (hit),
        .hit_way_o      (hit_way),
        .victim_way_o   (victim_way),
        .victim_valid_o (victim_valid),
        .victim_dirty_o (victim_dirty),
        .victim_tag_o   (victim_tag)
    );

    llc_line_store u_line_store (
        .clk       (clk),
        .rst       (rst),
        .rd_en_i   (rd_en),
        .set_i     (set),
        .wr_en_i   (wr_en),
        .wr_way_i  (wr_way),
        .wr_line_i (wr_line),
        .lines_o   (lines)
    );

endmodule

// File: verification/llc_clk_gen.sv
module llc_clk_gen (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    initial begin
        rst_o = 1'b0;
        repeat (5) @(posedge clk_o);
        rst_o <= 1'b1;  // released on the fifth rising edge
    end

endmodule

// File: verification/llc_props.sv
module llc_props import llc_pkg::*; (
    input logic       clk,
    input logic       rst,
    input logic       req_ready_i,
    input logic       rsp_valid_i,
    input logic       rsp_ready_i,
    input line_t      rsp_line_i,
    input req_id_t    rsp_id_i,
    input logic       mem_req_valid_i,
    input logic       mem_req_ready_i,
    input logic       mem_req_write_i,
    input line_addr_t mem_req_addr_i,
    input line_t      mem_req_line_i
);

    rsp_hold: assert property (@(posedge clk) disable iff (!rst)
        rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_line_i) && $stable(rsp_id_i))
        else $error("response dropped or changed before rsp_ready_i");

    mem_req_hold: assert property (@(posedge clk) disable iff (!rst)
        mem_req_valid_i && !mem_req_ready_i |=> mem_req_valid_i && $stable(mem_req_write_i)
        && $stable(mem_req_addr_i) && $stable(mem_req_line_i))
        else $error("memory request dropped or changed before mem_req_ready_i");

    // a new request must wait until the pending response is taken
    no_accept_while_responding: assert property (@(posedge clk) disable iff (!rst)
        !(req_ready_i && rsp_valid_i))
        else $error("req_ready_o and rsp_valid_o high together");

endmodule

bind llc_ctrl llc_props u_props (
    .clk             (clk),
    .rst             (rst),
    .req_ready_i     (req_ready_o),
    .rsp_valid_i     (rsp_valid_o),
    .rsp_ready_i     (rsp_ready_i),
    .rsp_line_i      (rsp_line_o),
    .rsp_id_i        (rsp_id_o),
    .mem_req_valid_i (mem_req_valid_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_req_write_i (mem_req_write_o),
    .mem_req_addr_i  (mem_req_addr_o),
    .mem_req_line_i  (mem_req_line_o)
);

// File: verification/llc_tb.sv
module llc_tb import llc_pkg::*; ();

    localparam int N_REQ = 300;
    localparam int CYCLE_LIMIT = 200 * N_REQ + 1000;

    logic clk, rst;
    logic req_valid_i, req_ready_o, req_write_i;
    line_addr_t req_addr_i;
    line_t req_line_i;
    req_id_t req_id_i;
    logic rsp_valid_o, rsp_ready_i;
    line_t rsp_line_o;
    req_id_t rsp_id_o;
    logic mem_req_valid_o, mem_req_ready_i, mem_req_write_o;
    line_addr_t mem_req_addr_o;
    line_t mem_req_line_o;
    logic mem_rsp_valid_i, mem_rsp_ready_o;
    line_t mem_rsp_line_i;

    logic [31:0] lfsr = 32'hdc943db0;
    logic stim_write [N_REQ];
    line_addr_t stim_addr [N_REQ];
    line_t stim_data [N_REQ];
    req_id_t stim_id [N_REQ];
    line_t shadow [line_addr_t];     // last line written by a request
    line_t mem_model [line_addr_t];  // contents of the backing memory
    llc_tag_t mdl_tag [LLC_SETS][LLC_WAYS];
    logic mdl_valid [LLC_SETS][LLC_WAYS];
    logic mdl_dirty [LLC_SETS][LLC_WAYS];
    int mdl_ptr [LLC_SETS];
    line_t exp_lines [$];
    req_id_t exp_ids [$];
    string cur_test;
    line_addr_t cur_addr, exp_wb_addr;
    int exp_reads, exp_writes, got_reads, got_writes;
    int rd_wait = 0;
    line_t rd_line;
    int rsp_count = 0;
    int cycle_count = 0;
    int mismatch_count = 0;
    int other_count = 0;

    llc_clk_gen u_clk_gen (.clk_o(clk), .rst_o(rst));

    llc_top u_dut (
        .clk(clk), .rst(rst),
        .req_valid_i(req_valid_i), .req_ready_o(req_ready_o), .req_write_i(req_write_i),
        .req_addr_i(req_addr_i), .req_line_i(req_line_i), .req_id_i(req_id_i),
        .rsp_valid_o(rsp_valid_o), .rsp_ready_i(rsp_ready_i), .rsp_line_o(rsp_line_o),
        .rsp_id_o(rsp_id_o),
        .mem_req_valid_o(mem_req_valid_o), .mem_req_ready_i(mem_req_ready_i),
        .mem_req_write_o(mem_req_write_o), .mem_req_addr_o(mem_req_addr_o),
        .mem_req_line_o(mem_req_line_o),
        .mem_rsp_valid_i(mem_rsp_valid_i), .mem_rsp_ready_o(mem_rsp_ready_o),
        .mem_rsp_line_i(mem_rsp_line_i)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic line_t addr_fill(input line_addr_t a);
        return {a, ~a, a ^ 16'h5aa5, {a[7:0], a[15:8]}};  // what memory holds before any write
    endfunction

    function automatic line_t ref_line(input logic wr, input line_addr_t a, input line_t d);
        if (wr) begin
            return d;
        end
        return shadow.exists(a) ? shadow[a] : addr_fill(a);
    endfunction

    task automatic report_mismatch(input string what, input logic [63:0] exp,
                                   input logic [63:0] act);
        $display("ERROR %s %s: expected %h, actual %h", cur_test, what, exp, act);
        mismatch_count++;
    endtask

    task automatic report_problem(input string msg);
        $display("%s (%s)", msg, cur_test);
        other_count++;
    endtask

    // 4 ways per set, filled in round-robin order
    task automatic predict_cache_access(input logic wr, input line_addr_t a);
        llc_set_t s;
        int way;
        logic hit;
        s = a[LLC_SET_BITS-1:0];
        hit = 1'b0;
        way = 0;
        exp_reads = 0;
        exp_writes = 0;
        for (int w = 0; w < LLC_WAYS; w++) begin
            if (mdl_valid[s][w] && mdl_tag[s][w] == a[LLC_SET_BITS +: LLC_TAG_BITS]) begin
                hit = 1'b1;
                way = w;
            end
        end
        if (!hit) begin
            way = mdl_ptr[s];
            if (mdl_valid[s][way] && mdl_dirty[s][way]) begin
                exp_writes = 1;
                exp_wb_addr = {mdl_tag[s][way], s};
            end
            exp_reads = 1;
            mdl_valid[s][way] = 1'b1;
            mdl_tag[s][way] = a[LLC_SET_BITS +: LLC_TAG_BITS];
            mdl_dirty[s][way] = 1'b0;
            mdl_ptr[s] = (mdl_ptr[s] + 1) % LLC_WAYS;
        end
        if (wr) begin
            mdl_dirty[s][way] = 1'b1;
        end
    endtask

    task automatic record_request(input int i);
        cur_test = $sformatf("request %0d %s", i, stim_write[i] ? "write" : "read");
        cur_addr = stim_addr[i];
        got_reads = 0;
        got_writes = 0;
        predict_cache_access(stim_write[i], stim_addr[i]);
        exp_lines.push_back(ref_line(stim_write[i], stim_addr[i], stim_data[i]));
        exp_ids.push_back(stim_id[i]);
        if (stim_write[i]) begin
            shadow[stim_addr[i]] = stim_data[i];
        end
    endtask

    initial begin
        int tag_idx;
        int set_idx;
        req_valid_i = 1'b0;
        req_write_i = 1'b0;
        req_addr_i = '0;
        req_line_i = '0;
        req_id_i = '0;
        rsp_ready_i = 1'b0;
        mem_req_ready_i = 1'b0;
        mem_rsp_valid_i = 1'b0;
        mem_rsp_line_i = '0;
        for (int s = 0; s < LLC_SETS; s++) begin
            mdl_ptr[s] = 0;
            for (int w = 0; w < LLC_WAYS; w++) begin
                mdl_valid[s][w] = 1'b0;
                mdl_dirty[s][w] = 1'b0;
                mdl_tag[s][w] = '0;
            end
        end
        // 6 tags over 4 sets, so sets overflow their ways
        for (int i = 0; i < N_REQ; i++) begin
            stim_write[i] = take_bits(1);
            tag_idx = take_bits(3) % 6;
            set_idx = take_bits(2);
            stim_addr[i] = line_addr_t'((256 + tag_idx) * LLC_SETS + set_idx);
            stim_data[i] = take_bits(64);
            stim_id[i] = take_bits(4);
        end
        wait (rst);
        for (int i = 0; i < N_REQ; i++) begin
            @(posedge clk);
            req_valid_i <= 1'b1;
            req_write_i <= stim_write[i];
            req_addr_i <= stim_addr[i];
            req_line_i <= stim_data[i];
            req_id_i <= stim_id[i];
            @(posedge clk);
            while (!req_ready_o) @(posedge clk);
            req_valid_i <= 1'b0;
            if (exp_lines.size() != 0) begin  // the previous response must be taken first
                report_problem("request accepted while a response was still pending");
            end
            record_request(i);
        end
        while (rsp_count < N_REQ) @(posedge clk);
        repeat (5) @(posedge clk);
        if (rsp_count != N_REQ) begin
            report_problem("not every request got exactly one response");
        end
        $display("errors: %0d mismatches, %0d other failures, %0d of %0d responses", mismatch_count,
                 other_count, rsp_count, N_REQ);
        if (mismatch_count + other_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // ready stretches and the memory model share the one random stream
    always @(posedge clk) begin
        if (rst) begin
            rsp_ready_i <= (take_bits(2) != 2'b00);
            mem_req_ready_i <= (take_bits(2) != 2'b00);
            if (mem_rsp_valid_i && mem_rsp_ready_o) begin
                mem_rsp_valid_i <= 1'b0;
            end else if (rd_wait == 1) begin
                mem_rsp_valid_i <= 1'b1;
                mem_rsp_line_i <= rd_line;
                rd_wait <= 0;
            end else if (rd_wait > 1) begin
                rd_wait <= rd_wait - 1;
            end
            if (mem_req_valid_o && mem_req_ready_i) begin
                if (mem_req_write_o) begin
                    got_writes++;
                    if (exp_writes == 0) begin
                        report_problem("write-back issued although no dirty line was evicted");
                    end else if (mem_req_addr_o !== exp_wb_addr) begin
                        report_mismatch("write-back address", exp_wb_addr, mem_req_addr_o);
                    end
                    if (mem_req_line_o !== ref_line(1'b0, mem_req_addr_o, '0)) begin
                        report_mismatch("write-back line", ref_line(1'b0, mem_req_addr_o, '0),
                                        mem_req_line_o);
                    end
                    mem_model[mem_req_addr_o] = mem_req_line_o;
                end else begin
                    got_reads++;
                    if (mem_req_addr_o !== cur_addr) begin
                        report_mismatch("fill address", cur_addr, mem_req_addr_o);
                    end
                    rd_line <= mem_model.exists(mem_req_addr_o) ? mem_model[mem_req_addr_o]
                                                                : addr_fill(mem_req_addr_o);
                    rd_wait <= 1 + take_bits(2) % 3;
                end
            end
        end
    end

    always @(posedge clk) begin
        line_t exp_line;
        req_id_t exp_id;
        if (rst && rsp_valid_o && rsp_ready_i) begin
            if (exp_lines.size() == 0) begin
                report_problem("response arrived with no request outstanding");
            end else begin
                exp_line = exp_lines.pop_front();
                exp_id = exp_ids.pop_front();
                if (rsp_line_o !== exp_line) begin
                    report_mismatch("response line", exp_line, rsp_line_o);
                end
                if (rsp_id_o !== exp_id) begin
                    report_mismatch("response id", exp_id, rsp_id_o);
                end
                if (got_reads != exp_reads) begin
                    report_mismatch("memory read count", exp_reads, got_reads);
                end
                if (got_writes != exp_writes) begin
                    report_mismatch("write-back count", exp_writes, got_writes);
                end
            end
            rsp_count <= rsp_count + 1;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the run did not complete within %0d cycles", CYCLE_LIMIT);
            $display("errors: %0d mismatches, %0d other failures, %0d of %0d responses",
                     mismatch_count, other_count + 1, rsp_count, N_REQ);
            $display("Test failed");
            $finish;
        end
    end

endmodule

// File: compile.f
source/llc_pkg.sv
source/llc_tag_store.sv
source/llc_line_store.sv
source/llc_ctrl.sv
source/llc_top.sv
verification/llc_clk_gen.sv
verification/llc_props.sv
verification/llc_tb.sv
